// ==== bench/csr_unit_trace.txt ====
# v op addr data irq rnd | csr_data ill exc int eret priv_n target | priv wait
# op: 0 rw 1 rs 2 rc 3 rwi 4 rsi 5 rci 6 ecall b mret c sret d nop; rnd lines ignore csr_data
1 0 305 1000 0 0 0 0 0 0 0 3 0 3 0
1 0 105 2001 0 0 0 0 0 0 0 3 0 3 0
1 0 140 a5a5 0 0 0 0 0 0 0 3 0 3 0
1 1 140 0f00 0 0 a5a5 0 0 0 0 3 0 3 0
1 2 140 00a5 0 0 afa5 0 0 0 0 3 0 3 0
1 3 140 1f 0 0 af00 0 0 0 0 3 0 3 0
1 0 340 0 0 1 0 0 0 0 0 3 0 3 0
1 1 340 0 0 1 0 0 0 0 0 3 0 3 0
1 2 340 0 0 1 0 0 0 0 0 3 0 3 0
1 4 340 0 0 1 0 0 0 0 0 3 0 3 0
1 5 340 0 0 1 0 0 0 0 0 3 0 3 0
1 3 340 0 0 1 0 0 0 0 0 3 0 3 0
1 1 140 0 0 1 0 0 0 0 0 3 0 3 0
1 0 301 ffffffffffffffff 0 0 8000000000141101 0 0 0 0 3 0 3 0
1 1 301 0 0 0 8000000000141101 0 0 0 0 3 0 3 0
1 0 341 4000 0 0 0 0 0 0 0 3 0 3 0
1 b 000 0 0 0 0 0 0 0 1 0 4000 0 0
1 1 300 4004 0 0 0 1 1 0 0 3 1000 3 0
1 1 342 0 0 0 2 0 0 0 0 3 0 3 0
1 1 341 0 0 0 4004 0 0 0 0 3 0 3 0
1 0 7c0 4008 0 0 0 1 1 0 0 3 1000 3 0
1 1 342 0 0 0 2 0 0 0 0 3 0 3 0
1 0 302 100 0 0 0 0 0 0 0 3 0 3 0
1 0 300 0 0 0 1800 0 0 0 0 3 0 3 0
1 b 000 0 0 0 0 0 0 0 1 0 4008 0 0
1 6 000 5000 0 0 0 0 1 0 0 1 2000 1 0
1 1 142 0 0 0 8 0 0 0 0 1 0 1 0
1 1 141 0 0 0 5000 0 0 0 0 1 0 1 0
1 1 100 20 0 0 0 0 0 0 0 1 0 1 0
1 c 000 0 0 0 0 0 0 0 1 0 5000 0 0
1 c 000 5004 0 0 0 1 1 0 0 3 1000 3 0
1 1 300 0 0 0 22 0 0 0 0 3 0 3 0
1 1 342 0 0 0 2 0 0 0 0 3 0 3 0
1 0 304 80 0 0 0 0 0 0 0 3 0 3 0
1 1 300 8 0 0 22 0 0 0 0 3 0 3 0
0 d 000 6000 4 0 0 0 0 1 0 3 1000 3 1
1 1 342 0 0 0 8000000000000007 0 0 0 0 3 0 3 0
1 1 341 0 0 0 6000 0 0 0 0 3 0 3 0
1 0 303 2 0 0 0 0 0 0 0 3 0 3 0
1 1 104 2 0 0 0 0 0 0 0 3 0 3 0
1 1 144 2 0 0 0 0 0 0 0 3 0 3 0
1 2 300 1800 0 0 18a2 0 0 0 0 3 0 3 0
1 b 000 0 0 0 0 0 0 0 1 0 6000 0 0
0 d 000 7000 0 0 0 0 0 1 0 1 2000 1 1
1 1 142 0 0 0 8000000000000001 0 0 0 0 1 0 1 0
1 1 141 0 0 0 7000 0 0 0 0 1 0 1 0
1 2 144 2 0 0 2 0 0 0 0 1 0 1 0

// ==== bench/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit;
   import csr_pkg::*;
   import trap_pkg::*;

   localparam string TRACE_FILE = "bench/csr_unit_trace.txt";
   localparam int    WAIT_LIMIT = 50;

   logic       clk;
   logic       rst_n;
   logic       cmd_v;
   csr_cmd_t   cmd;
   irq_lines_t irq;
   word_t      csr_data;
   logic       illegal;
   trap_pkt_t  trap;
   priv_e      priv;
   logic       irq_pending;

   logic [31:0] lfsr_q;
   word_t       mscratch_model;
   word_t       sscratch_model;

   csr_unit i_csr_unit (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .cmd_v_i       (cmd_v),
      .cmd_i         (cmd),
      .irq_i         (irq),
      .csr_data_o    (csr_data),
      .illegal_o     (illegal),
      .trap_o        (trap),
      .priv_o        (priv),
      .irq_pending_o (irq_pending)
   );

   always #5 clk = ~clk;

   // Taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_word(output word_t w);
      for (int i = 0; i < 64; i++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         w[i]   = lfsr_q[0];
      end
   endtask

   // New CSR value after a read-modify-write
   function automatic word_t csr_result(input csr_op_e op, input word_t old, input word_t data);
      word_t imm;
      imm = {59'd0, data[4:0]};
      case (op)
         CSRRW:   return data;
         CSRRS:   return old | data;
         CSRRC:   return old & ~data;
         CSRRWI:  return imm;
         CSRRSI:  return old | imm;
         CSRRCI:  return old & ~imm;
         default: return old;
      endcase
   endfunction

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_trap(input string name, input trap_pkt_t got, input trap_pkt_t exp);
      if (got !== exp)
         report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_priv(input string name, input priv_e got, input priv_e exp);
      if (got !== exp)
         report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   initial
   begin
      int          fd;
      int          n;
      int          line_no;
      int          waited;
      string       line;
      logic        f_v;
      logic [3:0]  f_op;
      logic [11:0] f_addr;
      word_t       f_data;
      logic [2:0]  f_irq;
      logic        f_rnd;
      word_t       f_csr;
      logic        f_ill;
      logic        f_exc;
      logic        f_int;
      logic        f_eret;
      logic [1:0]  f_tpriv;
      word_t       f_target;
      logic [1:0]  f_priv;
      logic        f_wait;
      word_t       data;
      word_t       exp_data;
      trap_pkt_t   exp_trap;
      priv_e       exp_priv;
      logic        have_prev;

      clk            = 1'b0;
      rst_n          = 1'b0;
      cmd_v          = 1'b0;
      cmd            = '0;
      cmd.op         = NOP;
      irq            = '0;
      lfsr_q         = 32'h151e;
      mscratch_model = '0;
      sscratch_model = '0;
      exp_priv       = PRIV_M;
      have_prev      = 1'b0;
      line_no        = 0;

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      exp_trap        = '0;
      exp_trap.priv_n = PRIV_M;
      check_priv("priv_o", priv, PRIV_M);
      check_flag("illegal_o", illegal, 1'b0);
      check_flag("irq_pending_o", irq_pending, 1'b0);
      check_trap("trap_o", trap, exp_trap);

      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0)
         report_failure({"could not open the trace file ", TRACE_FILE});

      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         line_no++;
         if (n == 0 || line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     f_v, f_op, f_addr, f_data, f_irq, f_rnd, f_csr, f_ill,
                     f_exc, f_int, f_eret, f_tpriv, f_target, f_priv, f_wait);
         if (n != 15)
            report_failure($sformatf("trace line %0d does not hold 15 fields", line_no));

         @(negedge clk);
         // Privilege left behind by the previous command
         if (have_prev)
            check_priv("priv_o", priv, exp_priv);

         if (f_rnd)
            random_word(data);
         else
            data = f_data;
         cmd_v    = f_v;
         cmd.op   = csr_op_e'(f_op);
         cmd.addr = f_addr;
         cmd.data = data;
         irq      = f_irq;

         exp_data = f_csr;
         if (f_rnd && f_addr == ADDR_MSCRATCH)
            exp_data = mscratch_model;
         else if (f_rnd && f_addr == ADDR_SSCRATCH)
            exp_data = sscratch_model;
         exp_trap.exception = f_exc;
         exp_trap.interrupt = f_int;
         exp_trap.eret      = f_eret;
         exp_trap.priv_n    = priv_e'(f_tpriv);
         exp_trap.target    = f_target;

         #1;
         if (f_wait)
         begin
            waited = 0;
            while (!trap.interrupt)
            begin
               if (waited == WAIT_LIMIT)
                  report_failure($sformatf("no interrupt trap came for trace line %0d",
                                           line_no));
               @(negedge clk);
               #1;
               waited++;
            end
         end

         check_word("csr_data_o", csr_data, exp_data);
         check_flag("illegal_o", illegal, f_ill);
         // An enabled interrupt is pending only on the lines that wait for one
         check_flag("irq_pending_o", irq_pending, f_wait);
         check_trap("trap_o", trap, exp_trap);

         if (f_v && !f_ill && f_addr == ADDR_MSCRATCH)
            mscratch_model = csr_result(csr_op_e'(f_op), exp_data, data);
         if (f_v && !f_ill && f_addr == ADDR_SSCRATCH)
            sscratch_model = csr_result(csr_op_e'(f_op), exp_data, data);
         exp_priv  = priv_e'(f_priv);
         have_prev = 1'b1;
      end
      $fclose(fd);

      @(negedge clk);
      if (have_prev)
         check_priv("priv_o", priv, exp_priv);
      cmd_v = 1'b0;
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== hw/cause_encode.sv ====
`timescale 1ns/1ps

module cause_encode (
   input  trap_pkg::csr_cmd_t   cmd_i,
   input  csr_pkg::csr_state_t  state_i,
   output trap_pkg::exc_vec_t   exc_vec_o,
   output trap_pkg::irq_cause_t irq_o
);
   import csr_pkg::*;
   import trap_pkg::*;

   ecode_t   ecall_code;
   exc_vec_t pending;
   exc_vec_t m_set;
   exc_vec_t s_set;
   logic     m_en;
   logic     s_en;

   // 8, 9 or 11 for U, S or M
   assign ecall_code = ECODE_ECALL_U | ecode_t'(state_i.priv);

   always_comb
   begin
      exc_vec_o = '0;
      case (cmd_i.op)
         ECALL:       exc_vec_o[ecall_code]        = 1'b1;
         EBREAK:      exc_vec_o[ECODE_BREAK]       = 1'b1;
         ILLEGAL:     exc_vec_o[ECODE_ILLEGAL]     = 1'b1;
         LOAD_FAULT:  exc_vec_o[ECODE_LOAD_FAULT]  = 1'b1;
         STORE_FAULT: exc_vec_o[ECODE_STORE_FAULT] = 1'b1;
         default:     exc_vec_o = '0;
      endcase
   end

   // Global enables for each target mode
   assign m_en = (state_i.priv != PRIV_M) || state_i.mstatus[MSTATUS_MIE];
   assign s_en = (state_i.priv == PRIV_U)
              || ((state_i.priv == PRIV_S) && state_i.mstatus[MSTATUS_SIE]);

   assign pending = state_i.mip[ECODE_W-1:0] & state_i.mie[ECODE_W-1:0];
   assign m_set   = pending & ~state_i.mideleg[ECODE_W-1:0] & {ECODE_W{m_en}};
   assign s_set   = pending & state_i.mideleg[ECODE_W-1:0] & {ECODE_W{s_en}};

   // M encoder beats S encoder
   assign irq_o.valid = (|m_set) | (|s_set);
   assign irq_o.to_s  = ~(|m_set);
   assign irq_o.code  = (|m_set) ? lowest_code(m_set) : lowest_code(s_set);

endmodule

// ==== hw/csr_access.sv ====
`timescale 1ns/1ps

module csr_access (
   input  trap_pkg::csr_cmd_t  cmd_i,
   input  csr_pkg::csr_state_t state_i,
   output csr_pkg::word_t      rdata_o,
   output csr_pkg::word_t      wdata_o,
   output logic                wr_o,
   output logic                illegal_o
);
   import csr_pkg::*;
   import trap_pkg::*;

   logic  is_csr_op;
   logic  known;
   logic  priv_fail;
   word_t imm;
   word_t rmw;

   assign is_csr_op = cmd_i.op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};

   // Address bits 9:8 give the lowest privilege allowed
   assign priv_fail = cmd_i.addr[9:8] > state_i.priv;

   always_comb
   begin
      known = 1'b1;
      case (cmd_i.addr)
         ADDR_SSTATUS:  rdata_o = state_i.mstatus & SSTATUS_MASK;
         ADDR_SIE:      rdata_o = state_i.mie & state_i.mideleg;
         ADDR_STVEC:    rdata_o = state_i.stvec;
         ADDR_SSCRATCH: rdata_o = state_i.sscratch;
         ADDR_SEPC:     rdata_o = state_i.sepc;
         ADDR_SCAUSE:   rdata_o = state_i.scause;
         ADDR_STVAL:    rdata_o = state_i.stval;
         ADDR_SIP:      rdata_o = state_i.mip & state_i.mideleg;
         ADDR_MSTATUS:  rdata_o = state_i.mstatus;
         ADDR_MISA:     rdata_o = MISA_VALUE;
         ADDR_MEDELEG:  rdata_o = state_i.medeleg;
         ADDR_MIDELEG:  rdata_o = state_i.mideleg;
         ADDR_MIE:      rdata_o = state_i.mie;
         ADDR_MTVEC:    rdata_o = state_i.mtvec;
         ADDR_MSCRATCH: rdata_o = state_i.mscratch;
         ADDR_MEPC:     rdata_o = state_i.mepc;
         ADDR_MCAUSE:   rdata_o = state_i.mcause;
         ADDR_MTVAL:    rdata_o = state_i.mtval;
         ADDR_MIP:      rdata_o = state_i.mip;
         default:
         begin
            rdata_o = '0;
            known   = 1'b0;
         end
      endcase
   end

   assign illegal_o = is_csr_op && (priv_fail || !known);

   // misa is read-only
   assign wr_o = is_csr_op && known && !priv_fail && (cmd_i.addr != ADDR_MISA);

   assign imm = word_t'(cmd_i.data[4:0]);

   always_comb
   begin
      case (cmd_i.op)
         CSRRW:   rmw = cmd_i.data;
         CSRRS:   rmw = rdata_o | cmd_i.data;
         CSRRC:   rmw = rdata_o & ~cmd_i.data;
         CSRRWI:  rmw = imm;
         CSRRSI:  rmw = rdata_o | imm;
         CSRRCI:  rmw = rdata_o & ~imm;
         default: rmw = rdata_o;
      endcase
   end

   // Supervisor views merge back into the machine register
   always_comb
   begin
      case (cmd_i.addr)
         ADDR_SSTATUS: wdata_o = (state_i.mstatus & ~SSTATUS_MASK) | (rmw & SSTATUS_MASK);
         ADDR_SIE:     wdata_o = (state_i.mie & ~state_i.mideleg) | (rmw & state_i.mideleg);
         ADDR_SIP:     wdata_o = (state_i.mip & ~state_i.mideleg) | (rmw & state_i.mideleg);
         default:      wdata_o = rmw;
      endcase
   end

endmodule

// ==== hw/csr_pkg.sv ====
package csr_pkg;

   typedef logic [63:0] word_t;
   typedef logic [11:0] csr_addr_t;

   // Supervisor CSRs
   localparam csr_addr_t ADDR_SSTATUS  = 12'h100;
   localparam csr_addr_t ADDR_SIE      = 12'h104;
   localparam csr_addr_t ADDR_STVEC    = 12'h105;
   localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
   localparam csr_addr_t ADDR_SEPC     = 12'h141;
   localparam csr_addr_t ADDR_SCAUSE   = 12'h142;
   localparam csr_addr_t ADDR_STVAL    = 12'h143;
   localparam csr_addr_t ADDR_SIP      = 12'h144;

   // Machine CSRs
   localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
   localparam csr_addr_t ADDR_MISA     = 12'h301;
   localparam csr_addr_t ADDR_MEDELEG  = 12'h302;
   localparam csr_addr_t ADDR_MIDELEG  = 12'h303;
   localparam csr_addr_t ADDR_MIE      = 12'h304;
   localparam csr_addr_t ADDR_MTVEC    = 12'h305;
   localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
   localparam csr_addr_t ADDR_MEPC     = 12'h341;
   localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
   localparam csr_addr_t ADDR_MTVAL    = 12'h343;
   localparam csr_addr_t ADDR_MIP      = 12'h344;

   // RV64 IMA with S and U modes
   localparam word_t MISA_VALUE = 64'h8000_0000_0014_1101;

   // mstatus bit positions
   localparam int MSTATUS_SIE  = 1;
   localparam int MSTATUS_MIE  = 3;
   localparam int MSTATUS_SPIE = 5;
   localparam int MSTATUS_MPIE = 7;
   localparam int MSTATUS_SPP  = 8;
   localparam int MSTATUS_MPP  = 11;

   localparam word_t SSTATUS_MASK  = 64'h0000_0000_0000_0122;
   localparam word_t MSTATUS_WMASK = 64'h0000_0000_0000_19aa;
   // SSIP, STIP and SEIP
   localparam word_t MIP_SW_WMASK  = 64'h0000_0000_0000_0222;

   typedef struct packed {
      logic [1:0] priv;
      word_t      mstatus;
      word_t      medeleg;
      word_t      mideleg;
      word_t      mie;
      word_t      mip;
      word_t      mtvec;
      word_t      stvec;
      word_t      mscratch;
      word_t      sscratch;
      word_t      mepc;
      word_t      sepc;
      word_t      mcause;
      word_t      scause;
      word_t      mtval;
      word_t      stval;
   } csr_state_t;

   // One strobe per field of csr_state_t
   typedef struct packed {
      logic priv;
      logic mstatus;
      logic medeleg;
      logic mideleg;
      logic mie;
      logic mip;
      logic mtvec;
      logic stvec;
      logic mscratch;
      logic sscratch;
      logic mepc;
      logic sepc;
      logic mcause;
      logic scause;
      logic mtval;
      logic stval;
   } csr_we_t;

   typedef struct packed {
      csr_we_t    we;
      csr_state_t val;
   } csr_update_t;

endpackage

// ==== hw/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  trap_pkg::irq_lines_t irq_lines_i,
   input  csr_pkg::csr_update_t update_i,
   output csr_pkg::csr_state_t  state_o
);
   import csr_pkg::*;
   import trap_pkg::*;

   csr_state_t state_q;
   word_t      mip_sw;
   word_t      mip_hw;

   // Software bits of mip, kept or replaced
   assign mip_sw = (update_i.we.mip ? update_i.val.mip : state_q.mip) & MIP_SW_WMASK;

   always_comb
   begin
      mip_hw          = '0;
      mip_hw[IRQ_MSI] = irq_lines_i.software;
      mip_hw[IRQ_MTI] = irq_lines_i.timer;
      mip_hw[IRQ_MEI] = irq_lines_i.external;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q      <= '0;
         state_q.priv <= PRIV_M;
      end
      else
      begin
         state_q.mip <= mip_sw | mip_hw;
         if (update_i.we.priv)
            state_q.priv <= update_i.val.priv;
         if (update_i.we.mstatus)
            state_q.mstatus <= update_i.val.mstatus & MSTATUS_WMASK;
         if (update_i.we.medeleg)
            state_q.medeleg <= update_i.val.medeleg;
         if (update_i.we.mideleg)
            state_q.mideleg <= update_i.val.mideleg;
         if (update_i.we.mie)
            state_q.mie <= update_i.val.mie;
         if (update_i.we.mtvec)
            state_q.mtvec <= update_i.val.mtvec;
         if (update_i.we.stvec)
            state_q.stvec <= update_i.val.stvec;
         if (update_i.we.mscratch)
            state_q.mscratch <= update_i.val.mscratch;
         if (update_i.we.sscratch)
            state_q.sscratch <= update_i.val.sscratch;
         if (update_i.we.mepc)
            state_q.mepc <= update_i.val.mepc;
         if (update_i.we.sepc)
            state_q.sepc <= update_i.val.sepc;
         if (update_i.we.mcause)
            state_q.mcause <= update_i.val.mcause;
         if (update_i.we.scause)
            state_q.scause <= update_i.val.scause;
         if (update_i.we.mtval)
            state_q.mtval <= update_i.val.mtval;
         if (update_i.we.stval)
            state_q.stval <= update_i.val.stval;
      end
   end

   assign state_o = state_q;

endmodule

// ==== hw/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 cmd_v_i,
   input  trap_pkg::csr_cmd_t   cmd_i,
   input  trap_pkg::irq_lines_t irq_i,
   output csr_pkg::word_t       csr_data_o,
   output logic                 illegal_o,
   output trap_pkg::trap_pkt_t  trap_o,
   output trap_pkg::priv_e      priv_o,
   output logic                 irq_pending_o
);
   import csr_pkg::*;
   import trap_pkg::*;

   csr_state_t  state;
   csr_update_t update;
   word_t       rdata;
   word_t       wdata;
   logic        wr;
   logic        access_illegal;
   exc_vec_t    exc_vec;
   irq_cause_t  irq_cause;

   csr_regs i_csr_regs (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .irq_lines_i (irq_i),
      .update_i    (update),
      .state_o     (state)
   );

   csr_access i_csr_access (
      .cmd_i     (cmd_i),
      .state_i   (state),
      .rdata_o   (rdata),
      .wdata_o   (wdata),
      .wr_o      (wr),
      .illegal_o (access_illegal)
   );

   cause_encode i_cause_encode (
      .cmd_i     (cmd_i),
      .state_i   (state),
      .exc_vec_o (exc_vec),
      .irq_o     (irq_cause)
   );

   trap_ctrl i_trap_ctrl (
      .cmd_v_i       (cmd_v_i),
      .cmd_i         (cmd_i),
      .state_i       (state),
      .rdata_i       (rdata),
      .wdata_i       (wdata),
      .wr_i          (wr),
      .illegal_i     (access_illegal),
      .exc_vec_i     (exc_vec),
      .irq_i         (irq_cause),
      .update_o      (update),
      .trap_o        (trap_o),
      .csr_data_o    (csr_data_o),
      .illegal_o     (illegal_o),
      .irq_pending_o (irq_pending_o)
   );

   assign priv_o = priv_e'(state.priv);

endmodule

// ==== hw/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl (
   input  logic                 cmd_v_i,
   input  trap_pkg::csr_cmd_t   cmd_i,
   input  csr_pkg::csr_state_t  state_i,
   input  csr_pkg::word_t       rdata_i,
   input  csr_pkg::word_t       wdata_i,
   input  logic                 wr_i,
   input  logic                 illegal_i,
   input  trap_pkg::exc_vec_t   exc_vec_i,
   input  trap_pkg::irq_cause_t irq_i,
   output csr_pkg::csr_update_t update_o,
   output trap_pkg::trap_pkt_t  trap_o,
   output csr_pkg::word_t       csr_data_o,
   output logic                 illegal_o,
   output logic                 irq_pending_o
);
   import csr_pkg::*;
   import trap_pkg::*;

   logic     is_mret;
   logic     is_sret;
   logic     ret_illegal;
   logic     ret_ok;
   logic     exc_taken;
   logic     irq_taken;
   logic     csr_wr;
   logic     to_s;
   exc_vec_t exc_all;
   ecode_t   exc_code;
   ecode_t   code;
   word_t    cause;

   assign is_mret     = cmd_i.op == MRET;
   assign is_sret     = cmd_i.op == SRET;
   assign ret_illegal = (is_mret && (state_i.priv != PRIV_M))
                     || (is_sret && (state_i.priv == PRIV_U));
   assign illegal_o   = cmd_v_i && (illegal_i || ret_illegal);

   assign exc_all   = exc_vec_i | (exc_vec_t'(illegal_o) << ECODE_ILLEGAL);
   assign exc_code  = lowest_code(exc_all);
   assign exc_taken = cmd_v_i && (|exc_all);
   assign ret_ok    = cmd_v_i && (is_mret || is_sret) && !ret_illegal;
   assign csr_wr    = cmd_v_i && wr_i;
   // Interrupts only between commands
   assign irq_taken = !cmd_v_i && irq_i.valid;

   assign to_s  = exc_taken ? (state_i.medeleg[exc_code] && (state_i.priv != PRIV_M))
                            : irq_i.to_s;
   assign code  = exc_taken ? exc_code : irq_i.code;
   assign cause = {irq_taken, 59'd0, code};

   always_comb
   begin
      update_o      = '0;
      update_o.val  = state_i;
      trap_o        = '0;
      trap_o.priv_n = priv_e'(state_i.priv);
      if (exc_taken || irq_taken)
      begin
         trap_o.exception    = exc_taken;
         trap_o.interrupt    = irq_taken;
         update_o.we.mstatus = 1'b1;
         if (to_s)
         begin
            trap_o.priv_n = PRIV_S;
            trap_o.target = {state_i.stvec[63:2], 2'b00};
            update_o.val.mstatus[MSTATUS_SPP]  = state_i.priv[0];
            update_o.val.mstatus[MSTATUS_SPIE] = state_i.mstatus[MSTATUS_SIE];
            update_o.val.mstatus[MSTATUS_SIE]  = 1'b0;
            update_o.we.sepc    = 1'b1;
            update_o.we.scause  = 1'b1;
            update_o.we.stval   = 1'b1;
            update_o.val.sepc   = cmd_i.data;
            update_o.val.scause = cause;
            update_o.val.stval  = '0;
         end
         else
         begin
            trap_o.priv_n = PRIV_M;
            trap_o.target = {state_i.mtvec[63:2], 2'b00};
            update_o.val.mstatus[MSTATUS_MPP +: 2] = state_i.priv;
            update_o.val.mstatus[MSTATUS_MPIE]     = state_i.mstatus[MSTATUS_MIE];
            update_o.val.mstatus[MSTATUS_MIE]      = 1'b0;
            update_o.we.mepc    = 1'b1;
            update_o.we.mcause  = 1'b1;
            update_o.we.mtval   = 1'b1;
            update_o.val.mepc   = cmd_i.data;
            update_o.val.mcause = cause;
            update_o.val.mtval  = '0;
         end
      end
      else if (ret_ok)
      begin
         trap_o.eret         = 1'b1;
         update_o.we.mstatus = 1'b1;
         if (is_mret)
         begin
            trap_o.priv_n = priv_e'(state_i.mstatus[MSTATUS_MPP +: 2]);
            trap_o.target = state_i.mepc;
            update_o.val.mstatus[MSTATUS_MIE]      = state_i.mstatus[MSTATUS_MPIE];
            update_o.val.mstatus[MSTATUS_MPIE]     = 1'b1;
            update_o.val.mstatus[MSTATUS_MPP +: 2] = PRIV_U;
         end
         else
         begin
            trap_o.priv_n = priv_e'({1'b0, state_i.mstatus[MSTATUS_SPP]});
            trap_o.target = state_i.sepc;
            update_o.val.mstatus[MSTATUS_SIE]  = state_i.mstatus[MSTATUS_SPIE];
            update_o.val.mstatus[MSTATUS_SPIE] = 1'b1;
            update_o.val.mstatus[MSTATUS_SPP]  = 1'b0;
         end
      end
      else if (csr_wr)
      begin
         case (cmd_i.addr)
            ADDR_SSTATUS, ADDR_MSTATUS:
            begin
               update_o.we.mstatus  = 1'b1;
               update_o.val.mstatus = wdata_i;
            end
            ADDR_SIE, ADDR_MIE:
            begin
               update_o.we.mie  = 1'b1;
               update_o.val.mie = wdata_i;
            end
            ADDR_SIP, ADDR_MIP:
            begin
               update_o.we.mip  = 1'b1;
               update_o.val.mip = wdata_i;
            end
            ADDR_STVEC:
            begin
               update_o.we.stvec  = 1'b1;
               update_o.val.stvec = wdata_i;
            end
            ADDR_SSCRATCH:
            begin
               update_o.we.sscratch  = 1'b1;
               update_o.val.sscratch = wdata_i;
            end
            ADDR_SEPC:
            begin
               update_o.we.sepc  = 1'b1;
               update_o.val.sepc = wdata_i;
            end
            ADDR_SCAUSE:
            begin
               update_o.we.scause  = 1'b1;
               update_o.val.scause = wdata_i;
            end
            ADDR_STVAL:
            begin
               update_o.we.stval  = 1'b1;
               update_o.val.stval = wdata_i;
            end
            ADDR_MEDELEG:
            begin
               update_o.we.medeleg  = 1'b1;
               update_o.val.medeleg = wdata_i;
            end
            ADDR_MIDELEG:
            begin
               update_o.we.mideleg  = 1'b1;
               update_o.val.mideleg = wdata_i;
            end
            ADDR_MTVEC:
            begin
               update_o.we.mtvec  = 1'b1;
               update_o.val.mtvec = wdata_i;
            end
            ADDR_MSCRATCH:
            begin
               update_o.we.mscratch  = 1'b1;
               update_o.val.mscratch = wdata_i;
            end
            ADDR_MEPC:
            begin
               update_o.we.mepc  = 1'b1;
               update_o.val.mepc = wdata_i;
            end
            ADDR_MCAUSE:
            begin
               update_o.we.mcause  = 1'b1;
               update_o.val.mcause = wdata_i;
            end
            ADDR_MTVAL:
            begin
               update_o.we.mtval  = 1'b1;
               update_o.val.mtval = wdata_i;
            end
            default:
            begin
               update_o.we.mstatus = 1'b0;
            end
         endcase
      end
      update_o.we.priv  = trap_o.exception || trap_o.interrupt || trap_o.eret;
      update_o.val.priv = trap_o.priv_n;
   end

   // Old value is hidden on a rejected access
   assign csr_data_o    = illegal_o ? '0 : rdata_i;
   assign irq_pending_o = irq_i.valid;

endmodule

// ==== hw/trap_pkg.sv ====
package trap_pkg;

   typedef enum logic [1:0] {
      PRIV_U = 2'b00,
      PRIV_S = 2'b01,
      PRIV_M = 2'b11
   } priv_e;

   typedef enum logic [3:0] {
      CSRRW, CSRRS, CSRRC,
      CSRRWI, CSRRSI, CSRRCI,
      ECALL, EBREAK, ILLEGAL,
      LOAD_FAULT, STORE_FAULT,
      MRET, SRET, NOP
   } csr_op_e;

   typedef logic [3:0] ecode_t;

   localparam int ECODE_W = 16;

   typedef logic [ECODE_W-1:0] exc_vec_t;

   localparam ecode_t ECODE_ILLEGAL     = 4'd2;
   localparam ecode_t ECODE_BREAK       = 4'd3;
   localparam ecode_t ECODE_LOAD_FAULT  = 4'd5;
   localparam ecode_t ECODE_STORE_FAULT = 4'd7;
   // S and M ecall follow at +1 and +3
   localparam ecode_t ECODE_ECALL_U     = 4'd8;

   // Interrupt codes, same as the mip bit positions
   localparam ecode_t IRQ_MSI = 4'd3;
   localparam ecode_t IRQ_MTI = 4'd7;
   localparam ecode_t IRQ_MEI = 4'd11;

   typedef struct packed {
      csr_op_e            op;
      csr_pkg::csr_addr_t addr;
      csr_pkg::word_t     data;
   } csr_cmd_t;

   typedef struct packed {
      logic timer;
      logic software;
      logic external;
   } irq_lines_t;

   typedef struct packed {
      logic   valid;
      logic   to_s;
      ecode_t code;
   } irq_cause_t;

   typedef struct packed {
      logic           exception;
      logic           interrupt;
      logic           eret;
      priv_e          priv_n;
      csr_pkg::word_t target;
   } trap_pkt_t;

   // Lowest set bit wins
   function automatic ecode_t lowest_code(input exc_vec_t vec);
      ecode_t code;
      code = '0;
      for (int i = ECODE_W - 1; i >= 0; i--)
      begin
         if (vec[i])
            code = ecode_t'(i);
      end
      return code;
   endfunction

endpackage

// ==== list.f ====
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/csr_access.sv
hw/cause_encode.sv
hw/trap_ctrl.sv
hw/csr_regs.sv
hw/csr_unit.sv
bench/tb_csr_unit.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_csr_unit -f list.f -o sim_csr_unit \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_csr_unit > sim.log 2>&1 || true
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
